//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// geometry
	localparam int WORDS_PER_LINE = 8;
	localparam int NUM_SETS       = 64;
	localparam int NUM_WAYS       = 2;

	// address split: tag | index | word offset | byte offset
	localparam int WORD_OFF_W = 3;
	localparam int LINE_OFF_W = 5;
	localparam int INDEX_W    = 6;
	localparam int TAG_W      = 21;

	typedef logic [31:0]                  word_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [INDEX_W-1:0]           index_t;
	typedef logic [WORD_OFF_W-1:0]        word_off_t;
	typedef logic [3:0]                   byte_en_t;
	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE*32-1:0] line_t;
	typedef logic                         way_t;

	typedef enum logic [2:0] {
		INVALIDATING,
		LOOKUP,
		WB_DRAIN,
		REFILLING,
		INSTALL,
		REPLAY
	} ctrl_state_t;

	// store bytes over an existing word
	function automatic word_t byte_merge(input word_t old_word, input word_t new_word,
		input byte_en_t be);
		word_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

//--- dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_req_valid,
	input  dcache_pkg::word_t    i_addr,
	input  dcache_pkg::byte_en_t i_wen,
	input  dcache_pkg::word_t    i_wdata,
	input  logic                 fill_done,
	input  dcache_pkg::line_t    fill_line,
	input  dcache_pkg::word_t    fill_word,
	input  logic                 wb_full,
	output logic                  o_stall,
	output logic                  o_resp_valid,
	output dcache_pkg::word_t     o_rdata,
	output logic                  o_mem_rd_req,
	output dcache_pkg::word_t     o_mem_rd_addr,
	output dcache_pkg::word_off_t o_miss_off,
	output dcache_pkg::byte_en_t  o_miss_wen,
	output dcache_pkg::word_t     o_miss_wdata,
	output logic                  o_wb_push,
	output dcache_pkg::word_t     o_wb_addr,
	output dcache_pkg::line_t     o_wb_line
);
	import dcache_pkg::*;

	// storage, indexed [way][set]
	tag_t                tag_mem  [NUM_WAYS][NUM_SETS];
	line_t               data_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
	// way to evict next, per set
	logic [NUM_SETS-1:0] lru_bits;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	index_t      sweep_cnt;

	index_t s1_index;
	logic   accept;

	// stage 2 request and the array words read for it
	logic                s2_valid;
	word_t               s2_addr;
	byte_en_t            s2_wen;
	word_t               s2_wdata;
	tag_t                s2_tag;
	index_t              s2_index;
	word_off_t           s2_off;
	logic [NUM_WAYS-1:0] rd_valid;
	tag_t                rd_tag  [NUM_WAYS];
	line_t               rd_line [NUM_WAYS];

	logic [NUM_WAYS-1:0] way_hit;
	logic                hit;
	way_t                hit_way;
	word_t               hit_word;
	word_t               store_word;
	logic                store_en;
	logic                miss;
	way_t                lru_way;

	// saved miss context
	word_t     save_addr;
	word_off_t save_off;
	byte_en_t  save_wen;
	word_t     save_wdata;
	index_t    save_index;
	tag_t      save_tag;
	way_t      vict_way;
	logic      vict_valid;
	tag_t      vict_tag;
	line_t     vict_line;

	assign s1_index = i_addr[LINE_OFF_W +: INDEX_W];
	assign s2_tag   = s2_addr[31 -: TAG_W];
	assign s2_index = s2_addr[LINE_OFF_W +: INDEX_W];
	assign s2_off   = s2_addr[2 +: WORD_OFF_W];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = rd_valid[w] && (rd_tag[w] == s2_tag);
		end
	end

	assign hit        = |way_hit;
	// two ways, so the upper hit bit names the way
	assign hit_way    = way_hit[1];
	assign hit_word   = rd_line[hit_way][s2_off*32 +: 32];
	assign store_word = byte_merge(hit_word, s2_wdata, s2_wen);
	assign store_en   = s2_valid && hit && (|s2_wen);
	assign miss       = s2_valid && !hit;
	assign lru_way    = lru_bits[s2_index];

	// stall is combinational on a stage 2 miss
	assign o_stall = (state != LOOKUP) || miss;
	assign accept  = i_req_valid && !o_stall;

	assign o_resp_valid = (s2_valid && hit) || ((state == REFILLING) && fill_done);
	assign o_rdata      = (state == REFILLING) ? fill_word : store_word;

	assign save_index    = save_addr[LINE_OFF_W +: INDEX_W];
	assign save_tag      = save_addr[31 -: TAG_W];
	assign o_mem_rd_req  = (state == WB_DRAIN) && !wb_full;
	assign o_mem_rd_addr = save_addr;
	assign o_miss_off    = save_off;
	assign o_miss_wen    = save_wen;
	assign o_miss_wdata  = save_wdata;

	// victim leaves while the new line goes in
	assign o_wb_push = (state == INSTALL) && vict_valid;
	assign o_wb_addr = {vict_tag, save_index, {LINE_OFF_W{1'b0}}};
	assign o_wb_line = vict_line;

	always_comb begin
		state_nxt = state;
		case (state)
			INVALIDATING: begin
				if (sweep_cnt == index_t'(NUM_SETS - 1)) begin
					state_nxt = LOOKUP;
				end
			end
			LOOKUP: begin
				if (miss) begin
					state_nxt = WB_DRAIN;
				end
			end
			// one victim entry, so the refill waits for it to drain
			WB_DRAIN: begin
				if (!wb_full) begin
					state_nxt = REFILLING;
				end
			end
			REFILLING: begin
				if (fill_done) begin
					state_nxt = INSTALL;
				end
			end
			INSTALL: state_nxt = REPLAY;
			// arrays now show the installed line for the held request
			REPLAY: state_nxt = LOOKUP;
			default: state_nxt = INVALIDATING;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= INVALIDATING;
			sweep_cnt <= '0;
			s2_valid  <= 1'b0;
		end else begin
			state    <= state_nxt;
			s2_valid <= accept;
			if (state == INVALIDATING) begin
				sweep_cnt <= sweep_cnt + 1'b1;
			end
		end
	end

	// valid and lru bits, cleared one set per cycle by the sweep
	always_ff @(posedge i_clk) begin
		if (state == INVALIDATING) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_bits[w][sweep_cnt] <= 1'b0;
			end
			lru_bits[sweep_cnt] <= 1'b0;
		end else if (state == INSTALL) begin
			valid_bits[vict_way][save_index] <= 1'b1;
			lru_bits[save_index]             <= ~vict_way;
		end else if (s2_valid && hit) begin
			lru_bits[s2_index] <= ~hit_way;
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == INSTALL) begin
			tag_mem[vict_way][save_index]  <= save_tag;
			data_mem[vict_way][save_index] <= fill_line;
		end else if (store_en) begin
			data_mem[hit_way][s2_index][s2_off*32 +: 32] <= store_word;
		end
	end

	// stage 1 read
	always_ff @(posedge i_clk) begin
		if (accept) begin
			s2_addr  <= i_addr;
			s2_wen   <= i_wen;
			s2_wdata <= i_wdata;
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			rd_valid[w] <= valid_bits[w][s1_index];
			rd_tag[w]   <= tag_mem[w][s1_index];
			rd_line[w]  <= data_mem[w][s1_index];
			// store landing this edge would be missed by the array read
			if (store_en && (hit_way == way_t'(w)) && (s2_index == s1_index)) begin
				rd_line[w][s2_off*32 +: 32] <= store_word;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (miss) begin
			save_addr  <= {s2_addr[31:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
			save_off   <= s2_off;
			save_wen   <= s2_wen;
			save_wdata <= s2_wdata;
			vict_way   <= lru_way;
			vict_valid <= rd_valid[lru_way];
			vict_tag   <= rd_tag[lru_way];
			vict_line  <= rd_line[lru_way];
		end
	end

endmodule

`default_nettype wire

//--- dcache_refill_buf.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_refill_buf (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  fill_start,
	input  dcache_pkg::word_off_t miss_off,
	input  dcache_pkg::byte_en_t  miss_wen,
	input  dcache_pkg::word_t     miss_wdata,
	input  logic                  i_mem_rd_valid,
	input  dcache_pkg::word_t     i_mem_rd_data,
	input  logic                  i_mem_rd_last,
	output logic                  o_fill_done,
	output dcache_pkg::line_t     o_fill_line,
	output dcache_pkg::word_t     o_fill_word
);
	import dcache_pkg::*;

	// next beat position, refill always starts at word 0
	word_off_t beat_cnt;
	logic      done_q;

	// store saved from the missing request
	word_off_t crit_off;
	byte_en_t  st_wen;
	word_t     st_wdata;

	line_t line_q;
	word_t crit_q;
	logic  beat_hit;
	word_t beat_word;

	assign beat_hit  = (beat_cnt == crit_off);
	// a load miss has no enables, so the beat passes unchanged
	assign beat_word = beat_hit ? byte_merge(i_mem_rd_data, st_wdata, st_wen) : i_mem_rd_data;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			beat_cnt <= '0;
			done_q   <= 1'b0;
		end else begin
			done_q <= i_mem_rd_valid && i_mem_rd_last;
			if (fill_start) begin
				beat_cnt <= '0;
			end else if (i_mem_rd_valid) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (fill_start) begin
			crit_off <= miss_off;
			st_wen   <= miss_wen;
			st_wdata <= miss_wdata;
		end
		if (i_mem_rd_valid) begin
			line_q[beat_cnt*32 +: 32] <= beat_word;
			if (beat_hit) begin
				crit_q <= beat_word;
			end
		end
	end

	// line and word hold until the next fill
	assign o_fill_done = done_q;
	assign o_fill_line = line_q;
	assign o_fill_word = crit_q;

endmodule

`default_nettype wire

//--- dcache_victim_wb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_victim_wb (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              wb_push,
	input  dcache_pkg::word_t wb_addr,
	input  dcache_pkg::line_t wb_line,
	input  logic              i_mem_wr_done,
	output logic              o_wb_full,
	output logic              o_mem_wr_req,
	output dcache_pkg::word_t o_mem_wr_addr,
	output dcache_pkg::line_t o_mem_wr_line
);
	import dcache_pkg::*;

	logic  full_q;
	logic  req_q;
	word_t addr_q;
	line_t line_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full_q <= 1'b0;
			req_q  <= 1'b0;
		end else begin
			// single request pulse per pushed line
			req_q <= wb_push;
			if (wb_push) begin
				full_q <= 1'b1;
			end else if (i_mem_wr_done) begin
				full_q <= 1'b0;
			end
		end
	end

	// held until memory reports the write done
	always_ff @(posedge i_clk) begin
		if (wb_push) begin
			addr_q <= wb_addr;
			line_q <= wb_line;
		end
	end

	assign o_wb_full     = full_q;
	assign o_mem_wr_req  = req_q;
	assign o_mem_wr_addr = addr_q;
	assign o_mem_wr_line = line_q;

endmodule

`default_nettype wire

//--- dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_req_valid,
	input  dcache_pkg::word_t    i_addr,
	input  dcache_pkg::byte_en_t i_wen,
	input  dcache_pkg::word_t    i_wdata,
	input  logic                 i_mem_rd_valid,
	input  dcache_pkg::word_t    i_mem_rd_data,
	input  logic                 i_mem_rd_last,
	input  logic                 i_mem_wr_done,
	output logic                 o_stall,
	output logic                 o_resp_valid,
	output dcache_pkg::word_t    o_rdata,
	output logic                 o_mem_rd_req,
	output dcache_pkg::word_t    o_mem_rd_addr,
	output logic                 o_mem_wr_req,
	output dcache_pkg::word_t    o_mem_wr_addr,
	output dcache_pkg::line_t    o_mem_wr_line,
	output logic                 o_wb_full
);
	import dcache_pkg::*;

	// refill path
	logic      fill_start;
	word_off_t miss_off;
	byte_en_t  miss_wen;
	word_t     miss_wdata;
	logic      fill_done;
	line_t     fill_line;
	word_t     fill_word;

	// victim path
	logic  wb_push;
	word_t wb_addr;
	line_t wb_line;
	logic  wb_full;

	// the memory read request also starts the line buffer
	assign o_mem_rd_req = fill_start;
	assign o_wb_full    = wb_full;

	dcache_lookup dcache_lookup_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_req_valid  (i_req_valid),
		.i_addr       (i_addr),
		.i_wen        (i_wen),
		.i_wdata      (i_wdata),
		.fill_done    (fill_done),
		.fill_line    (fill_line),
		.fill_word    (fill_word),
		.wb_full      (wb_full),
		.o_stall      (o_stall),
		.o_resp_valid (o_resp_valid),
		.o_rdata      (o_rdata),
		.o_mem_rd_req (fill_start),
		.o_mem_rd_addr(o_mem_rd_addr),
		.o_miss_off   (miss_off),
		.o_miss_wen   (miss_wen),
		.o_miss_wdata (miss_wdata),
		.o_wb_push    (wb_push),
		.o_wb_addr    (wb_addr),
		.o_wb_line    (wb_line)
	);

	dcache_refill_buf dcache_refill_buf_i (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.fill_start    (fill_start),
		.miss_off      (miss_off),
		.miss_wen      (miss_wen),
		.miss_wdata    (miss_wdata),
		.i_mem_rd_valid(i_mem_rd_valid),
		.i_mem_rd_data (i_mem_rd_data),
		.i_mem_rd_last (i_mem_rd_last),
		.o_fill_done   (fill_done),
		.o_fill_line   (fill_line),
		.o_fill_word   (fill_word)
	);

	dcache_victim_wb dcache_victim_wb_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.wb_push      (wb_push),
		.wb_addr      (wb_addr),
		.wb_line      (wb_line),
		.i_mem_wr_done(i_mem_wr_done),
		.o_wb_full    (wb_full),
		.o_mem_wr_req (o_mem_wr_req),
		.o_mem_wr_addr(o_mem_wr_addr),
		.o_mem_wr_line(o_mem_wr_line)
	);

endmodule

`default_nettype wire

//--- tb_dcache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_assert (
	input wire logic        i_clk,
	input wire logic        i_rst,
	input wire logic        i_req_valid,
	input wire logic        i_mem_wr_done,
	input wire logic        o_stall,
	input wire logic        o_resp_valid,
	input wire logic        o_mem_rd_req,
	input wire logic        o_mem_wr_req,
	input wire logic        o_wb_full,
	input wire logic [31:0] o_mem_wr_addr
);

	logic       accept;
	// victim write requested and not yet acknowledged
	logic       wr_pending;
	logic       wr_busy;
	// accepted requests still waiting for their response
	logic [1:0] open_cnt;

	assign accept  = i_req_valid && !o_stall;
	assign wr_busy = o_mem_wr_req || wr_pending;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_pending <= 1'b0;
			open_cnt   <= '0;
		end else begin
			if (o_mem_wr_req) begin
				wr_pending <= 1'b1;
			end else if (i_mem_wr_done) begin
				wr_pending <= 1'b0;
			end
			open_cnt <= open_cnt + {1'b0, accept} - {1'b0, o_resp_valid};
		end
	end

	// one victim entry, so no refill while its write is outstanding
	rd_while_wr_busy: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_mem_rd_req && wr_busy))
		else $error("memory read issued while a victim write is pending");

	wb_full_tracks_write: assert property (@(posedge i_clk) disable iff (i_rst)
		o_wb_full == wr_busy)
		else $error("victim buffer full flag disagrees with the write handshake");

	// blocking cache, so the previous request is answered by the time the next is taken
	one_response_each: assert property (@(posedge i_clk) disable iff (i_rst)
		accept |-> (open_cnt == {1'b0, o_resp_valid}))
		else $error("request accepted while an earlier one is unanswered or over-answered");

	wr_addr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_wb_full && $past(o_wb_full)) |-> $stable(o_mem_wr_addr))
		else $error("victim write address changed while pending");

endmodule

bind dcache_top tb_dcache_assert dcache_assert_i (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_req_valid  (i_req_valid),
	.i_mem_wr_done(i_mem_wr_done),
	.o_stall      (o_stall),
	.o_resp_valid (o_resp_valid),
	.o_mem_rd_req (o_mem_rd_req),
	.o_mem_wr_req (o_mem_wr_req),
	.o_wb_full    (o_wb_full),
	.o_mem_wr_addr(o_mem_wr_addr)
);

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int CLK_PERIOD   = 8;
	localparam int N_FIXED      = 16;
	localparam int N_RAND       = 48;
	localparam int N_TESTS      = N_FIXED + N_RAND;
	localparam int MEM_WORDS    = 4096;
	// burst start, eight beats with gaps, victim drain, install and replay
	localparam int MISS_CYCLES  = 60;
	localparam int SWEEP_CYCLES = 80;
	localparam int KIND_ANY     = 0;
	localparam int KIND_HIT     = 1;
	localparam int KIND_MISS    = 2;

	// lines A, B and C share set 8, D sits in set 26
	localparam logic [31:0] LINE_A = 32'h0000_0100;
	localparam logic [31:0] LINE_B = 32'h0000_0900;
	localparam logic [31:0] LINE_C = 32'h0000_1100;
	localparam logic [31:0] LINE_D = 32'h0000_0340;

	logic         i_clk;
	logic         i_rst;
	logic         i_req_valid;
	logic [31:0]  i_addr;
	logic [3:0]   i_wen;
	logic [31:0]  i_wdata;
	logic         i_mem_rd_valid;
	logic [31:0]  i_mem_rd_data;
	logic         i_mem_rd_last;
	logic         i_mem_wr_done;
	logic         o_stall;
	logic         o_resp_valid;
	logic [31:0]  o_rdata;
	logic         o_mem_rd_req;
	logic [31:0]  o_mem_rd_addr;
	logic         o_mem_wr_req;
	logic [31:0]  o_mem_wr_addr;
	logic [255:0] o_mem_wr_line;
	logic         o_wb_full;

	// stimulus table
	logic [31:0] tbl_addr  [N_TESTS];
	logic [3:0]  tbl_wen   [N_TESTS];
	logic [31:0] tbl_wdata [N_TESTS];
	int          tbl_kind  [N_TESTS];

	// memory seen by the DUT, and the expected contents
	logic [31:0] mem     [MEM_WORDS];
	logic [31:0] ref_mem [MEM_WORDS];

	logic [31:0] exp_data_q [$];
	int          exp_idx_q  [$];
	int          acc_cyc_q  [$];

	int          seed;
	int          cyc;
	int          errors;
	int          resp_cnt;
	logic        rd_seen;
	logic        wb_b_seen;
	logic [31:0] rd_exp_addr;

	dcache_top dcache_top_i (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_req_valid   (i_req_valid),
		.i_addr        (i_addr),
		.i_wen         (i_wen),
		.i_wdata       (i_wdata),
		.i_mem_rd_valid(i_mem_rd_valid),
		.i_mem_rd_data (i_mem_rd_data),
		.i_mem_rd_last (i_mem_rd_last),
		.i_mem_wr_done (i_mem_wr_done),
		.o_stall       (o_stall),
		.o_resp_valid  (o_resp_valid),
		.o_rdata       (o_rdata),
		.o_mem_rd_req  (o_mem_rd_req),
		.o_mem_rd_addr (o_mem_rd_addr),
		.o_mem_wr_req  (o_mem_wr_req),
		.o_mem_wr_addr (o_mem_wr_addr),
		.o_mem_wr_line (o_mem_wr_line),
		.o_wb_full     (o_wb_full)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] fill_pattern(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
	endfunction

	function automatic logic [31:0] apply_store(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic add_entry(input int t, input logic [31:0] addr, input logic [3:0] wen,
		input logic [31:0] wdata, input int kind);
		tbl_addr[t]  = addr;
		tbl_wen[t]   = wen;
		tbl_wdata[t] = wdata;
		tbl_kind[t]  = kind;
	endtask

	task automatic build_table();
		logic [31:0] r;
		add_entry(0, LINE_A + 32'h00, 4'h0, 32'h0, KIND_MISS);
		add_entry(1, LINE_A + 32'h04, 4'h0, 32'h0, KIND_HIT);
		// four back-to-back hits
		add_entry(2, LINE_A + 32'h08, 4'h0, 32'h0, KIND_HIT);
		add_entry(3, LINE_A + 32'h0c, 4'h0, 32'h0, KIND_HIT);
		add_entry(4, LINE_A + 32'h10, 4'h0, 32'h0, KIND_HIT);
		add_entry(5, LINE_A + 32'h14, 4'h0, 32'h0, KIND_HIT);
		add_entry(6, LINE_A + 32'h08, 4'h3, 32'hdead_beef, KIND_HIT);
		add_entry(7, LINE_A + 32'h08, 4'h0, 32'h0, KIND_HIT);
		// write-allocate store
		add_entry(8, LINE_D + 32'h0c, 4'hc, 32'hcafe_f00d, KIND_MISS);
		add_entry(9, LINE_D + 32'h0c, 4'h0, 32'h0, KIND_HIT);
		// A, B, A, C leaves B as the LRU victim
		add_entry(10, LINE_B + 32'h00, 4'h0, 32'h0, KIND_MISS);
		add_entry(11, LINE_B + 32'h1c, 4'h9, 32'h1234_5678, KIND_HIT);
		add_entry(12, LINE_A + 32'h00, 4'h0, 32'h0, KIND_HIT);
		add_entry(13, LINE_C + 32'h04, 4'h0, 32'h0, KIND_MISS);
		add_entry(14, LINE_B + 32'h1c, 4'h0, 32'h0, KIND_MISS);
		add_entry(15, LINE_B + 32'h18, 4'h0, 32'h0, KIND_HIT);
		// four tags over two sets keep evictions frequent
		for (int i = N_FIXED; i < N_TESTS; i++) begin
			r = $random(seed);
			tbl_addr[i]  = 32'h100 + {19'd0, r[1:0], 11'd0} + {26'd0, r[2], 5'd0}
				+ {27'd0, r[5:3], 2'd0};
			tbl_wen[i]   = r[6] ? r[10:7] : 4'h0;
			tbl_wdata[i] = $random(seed);
			tbl_kind[i]  = KIND_ANY;
		end
	endtask

	task automatic check_sweep();
		for (int i = 0; i < 64; i++) begin
			assert (o_stall && !o_mem_rd_req && !o_mem_wr_req && !o_resp_valid && !o_wb_full)
			else begin
				$display("cache left its reset sweep early or was not idle in cycle %0d", i);
				errors++;
			end
			@(negedge i_clk);
		end
	endtask

	task automatic issue_request(input int t);
		int          idx;
		logic [31:0] merged;
		@(negedge i_clk);
		i_req_valid = 1'b1;
		i_addr      = tbl_addr[t];
		i_wen       = tbl_wen[t];
		i_wdata     = tbl_wdata[t];
		while (o_stall) begin
			@(negedge i_clk);
		end
		// accepted at the coming rising edge
		idx          = int'(tbl_addr[t][13:2]);
		merged       = apply_store(ref_mem[idx], tbl_wdata[t], tbl_wen[t]);
		ref_mem[idx] = merged;
		exp_data_q.push_back(merged);
		exp_idx_q.push_back(t);
		acc_cyc_q.push_back(cyc);
	endtask

	task automatic check_response();
		logic [31:0] exp;
		int          t;
		int          acc;
		int          errs_before;
		errs_before = errors;
		if (exp_data_q.size() == 0) begin
			$display("response arrived with no request outstanding");
			errors++;
			return;
		end
		exp = exp_data_q.pop_front();
		t   = exp_idx_q.pop_front();
		acc = acc_cyc_q.pop_front();
		resp_cnt++;
		assert (o_rdata === exp) else begin
			$display("mismatch test %0d o_rdata: got %h expected %h", t, o_rdata, exp);
			errors++;
		end
		if (tbl_kind[t] == KIND_HIT) begin
			assert (cyc - acc == 1 && !rd_seen) else begin
				$display("test %0d should hit but took %0d cycles or read memory",
					t, cyc - acc);
				errors++;
			end
		end
		if (tbl_kind[t] == KIND_MISS) begin
			assert (rd_seen) else begin
				$display("test %0d should miss but no memory read was made", t);
				errors++;
			end
		end
		rd_seen = 1'b0;
		$display("test %0d addr %h wen %h rdata %h %s", t, tbl_addr[t], tbl_wen[t],
			o_rdata, (errors == errs_before) ? "ok" : "failed");
	endtask

	always @(negedge i_clk) begin
		if (!i_rst && o_resp_valid) begin
			check_response();
		end
	end

	// one read per miss, for the line of the oldest outstanding request
	always @(negedge i_clk) begin
		if (!i_rst && o_mem_rd_req) begin
			assert (!rd_seen) else begin
				$display("second memory read issued for one miss");
				errors++;
			end
			assert (exp_idx_q.size() > 0) else begin
				$display("memory read issued with no request outstanding");
				errors++;
			end
			if (exp_idx_q.size() > 0) begin
				rd_exp_addr = {tbl_addr[exp_idx_q[0]][31:5], 5'd0};
				assert (o_mem_rd_addr === rd_exp_addr) else begin
					$display("mismatch o_mem_rd_addr: got %h expected %h", o_mem_rd_addr,
						rd_exp_addr);
					errors++;
				end
			end
			rd_seen = 1'b1;
		end
	end

	initial begin : mem_read_model
		int base;
		int gap;
		forever begin
			@(negedge i_clk);
			if (!i_rst && o_mem_rd_req) begin
				base = int'(o_mem_rd_addr[13:2]);
				gap  = 2 + $unsigned($random(seed)) % 4;
				repeat (gap) @(negedge i_clk);
				for (int b = 0; b < 8; b++) begin
					gap = $unsigned($random(seed)) % 3;
					repeat (gap) @(negedge i_clk);
					i_mem_rd_valid = 1'b1;
					i_mem_rd_data  = mem[base + b];
					i_mem_rd_last  = (b == 7);
					@(negedge i_clk);
					i_mem_rd_valid = 1'b0;
					i_mem_rd_last  = 1'b0;
				end
			end
		end
	end

	initial begin : mem_write_model
		int base;
		int delay;
		forever begin
			@(negedge i_clk);
			if (!i_rst && o_mem_wr_req) begin
				base = int'(o_mem_wr_addr[13:2]);
				if (o_mem_wr_addr == LINE_B) begin
					wb_b_seen = 1'b1;
				end
				for (int w = 0; w < 8; w++) begin
					assert (o_mem_wr_line[w*32 +: 32] === ref_mem[base + w]) else begin
						$display("mismatch o_mem_wr_line word %0d: got %h expected %h",
							w, o_mem_wr_line[w*32 +: 32], ref_mem[base + w]);
						errors++;
					end
					mem[base + w] = o_mem_wr_line[w*32 +: 32];
				end
				delay = 1 + $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge i_clk);
				i_mem_wr_done = 1'b1;
				@(negedge i_clk);
				i_mem_wr_done = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (SWEEP_CYCLES + N_TESTS * MISS_CYCLES) @(posedge i_clk);
		$display("timeout with %0d of %0d responses received", resp_cnt, N_TESTS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		seed           = 92890;
		cyc            = 0;
		errors         = 0;
		resp_cnt       = 0;
		rd_seen        = 1'b0;
		wb_b_seen      = 1'b0;
		i_rst          = 1'b1;
		i_req_valid    = 1'b0;
		i_addr         = 32'h0;
		i_wen          = 4'h0;
		i_wdata        = 32'h0;
		i_mem_rd_valid = 1'b0;
		i_mem_rd_data  = 32'h0;
		i_mem_rd_last  = 1'b0;
		i_mem_wr_done  = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]     = fill_pattern(32'(i * 4));
			ref_mem[i] = mem[i];
		end
		build_table();
		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		check_sweep();
		for (int t = 0; t < N_TESTS; t++) begin
			issue_request(t);
		end
		@(negedge i_clk);
		i_req_valid = 1'b0;
		while (resp_cnt < N_TESTS) begin
			@(negedge i_clk);
		end
		assert (wb_b_seen) else begin
			$display("line B was never written back after its eviction");
			errors++;
		end
		$display("tests %0d responses %0d errors %0d", N_TESTS, resp_cnt, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dcache.f
dcache_pkg.sv
dcache_lookup.sv
dcache_refill_buf.sv
dcache_victim_wb.sv
dcache_top.sv
tb_dcache_assert.sv
tb_dcache.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f dcache.f --top-module tb_dcache \
		-o tb_dcache_sim

run: compile
	@out="$$(./obj_dir/tb_dcache_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
